//--- Makefile
# Verilator build and run of the dtlb testbench

VERILATOR ?= verilator
TOP       ?= tb_dtlb
FILELIST  ?= dtlb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_MSG  ?= RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR) \
		$(VFLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/dtlb_checker.sv
/*
  dtlb_checker
  Watches the data TLB outputs. Times the reset sweep through wr_ready,
  and compares the lookup results against the expected values that the
  testbench hands over with chk_en.
*/
`timescale 1ns/1ps

module dtlb_checker (
  input  logic                                                             clk,
  input  logic                                                             rst,
  input  logic                                                             wr_ready,
  input  logic [tlb_geom_pkg::num_ports-1:0]                               lk_hit,
  input  logic [tlb_geom_pkg::num_ports-1:0][tlb_geom_pkg::ppn_bits-1:0]  lk_ppn,
  input  logic [tlb_geom_pkg::num_ports-1:0][tlb_geom_pkg::perm_bits-1:0] lk_perm,
  input  logic [tlb_geom_pkg::num_ports-1:0][tlb_geom_pkg::way_bits-1:0]  lk_way,
  input  logic                                                             chk_en,
  input  logic [8*16-1:0]                                                  test_name,
  input  logic [tlb_geom_pkg::num_ports-1:0]                               exp_hit,
  input  logic [tlb_geom_pkg::num_ports-1:0][tlb_geom_pkg::way_bits-1:0]  exp_way,
  input  logic [tlb_geom_pkg::num_ports-1:0][tlb_geom_pkg::ppn_bits-1:0]  exp_ppn,
  input  logic [tlb_geom_pkg::num_ports-1:0][tlb_geom_pkg::perm_bits-1:0] exp_perm,
  output int                                                               pass_cnt,
  output int                                                               fail_cnt
);
  import tlb_geom_pkg::*;

  int low_cycles;
  bit sweep_done;
  bit row_bad;

  // names arrive right aligned with leading zero bytes
  function automatic string name_text(input logic [8*16-1:0] v);
    string      s;
    logic [7:0] c;
    s = "";
    for (int i = 15; i >= 0; i--) begin
      c = v[i*8 +: 8];
      if (c != 8'h00) begin
        s = $sformatf("%s%c", s, c);
      end
    end
    return s;
  endfunction

  // first mismatch of a row gives its line
  task automatic field_fail(input int port, input string field, input int exp_v,
                            input int act_v);
    if (!row_bad) begin
      $display("[FAIL] %s port %0d %s: expected %0h, actual %0h",
               name_text(test_name), port, field, exp_v, act_v);
    end
    row_bad = 1'b1;
  endtask

  task automatic check_row();
    row_bad = 1'b0;
    for (int p = 0; p < num_ports; p++) begin
      if (lk_hit[p] != exp_hit[p]) begin
        field_fail(p, "hit", int'(exp_hit[p]), int'(lk_hit[p]));
      end else if (exp_hit[p]) begin
        if (lk_way[p] != exp_way[p]) begin
          field_fail(p, "way", int'(exp_way[p]), int'(lk_way[p]));
        end
        if (lk_ppn[p] != exp_ppn[p]) begin
          field_fail(p, "ppn", int'(exp_ppn[p]), int'(lk_ppn[p]));
        end
        if (lk_perm[p] != exp_perm[p]) begin
          field_fail(p, "perm", int'(exp_perm[p]), int'(lk_perm[p]));
        end
      end
    end
    if (row_bad) begin
      fail_cnt++;
    end else begin
      pass_cnt++;
      $display("[PASS] %s", name_text(test_name));
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      pass_cnt   = 0;
      fail_cnt   = 0;
      low_cycles = 0;
      sweep_done = 1'b0;
    end else begin
      if (!sweep_done) begin
        if (wr_ready) begin
          sweep_done = 1'b1;
          if (low_cycles == sweep_len) begin
            pass_cnt++;
            $display("[PASS] sweep_ready");
          end else begin
            fail_cnt++;
            $display("[FAIL] sweep_ready: expected %0d, actual %0d", sweep_len, low_cycles);
          end
        end else begin
          low_cycles++;
        end
      end else if (!wr_ready) begin
        $display("wr_ready went low after the reset sweep had finished");
        fail_cnt++;
      end
      if (chk_en) begin
        check_row();
      end
    end
  end

endmodule

//--- bench/tb_dtlb.sv
/*
  tb_dtlb
  Testbench for the data TLB. Builds a table of write and lookup rows,
  applies it after the reset sweep and hands the expected lookup results
  to dtlb_checker one cycle after each row.
*/
`timescale 1ns/1ps

module tb_dtlb;
  import tlb_geom_pkg::*;
  import tlb_ctrl_pkg::*;

  localparam int num_rows    = 19;
  localparam int cycle_limit = 5 + sweep_len + num_rows * 3 + 50;

  // k_idle drives the lookups with lk_valid low
  typedef enum logic [1:0] {
    k_fill,
    k_inval,
    k_look,
    k_idle
  } kind_e;

  typedef struct packed {
    logic                 hit;
    logic [way_bits-1:0]  way;
    logic [ppn_bits-1:0]  ppn;
    logic [perm_bits-1:0] perm;
  } res_t;

  typedef struct packed {
    logic [8*16-1:0]      name;
    kind_e                kind;
    logic [vpn_bits-1:0]  vpn;
    logic [asid_bits-1:0] asid;
    logic [ppn_bits-1:0]  ppn;
    logic [perm_bits-1:0] perm;
    logic                 glob;
    logic [vpn_bits-1:0]  lk0;
    logic [vpn_bits-1:0]  lk1;
    logic [asid_bits-1:0] lk_asid;
    res_t                 exp0;
    res_t                 exp1;
  } row_t;

  logic clk = 1'b0;
  logic rst;
  logic                                    wr_valid;
  logic                                    wr_ready;
  tlb_op_e                                 wr_op;
  logic [vpn_bits-1:0]                     wr_vpn;
  logic [asid_bits-1:0]                    wr_asid;
  logic [ppn_bits-1:0]                     wr_ppn;
  logic [perm_bits-1:0]                    wr_perm;
  logic                                    wr_global;
  logic [num_ports-1:0]                    lk_valid;
  logic [num_ports-1:0][vpn_bits-1:0]      lk_vpn;
  logic [asid_bits-1:0]                    lk_asid;
  logic [num_ports-1:0]                    lk_hit;
  logic [num_ports-1:0][ppn_bits-1:0]      lk_ppn;
  logic [num_ports-1:0][perm_bits-1:0]     lk_perm;
  logic [num_ports-1:0][way_bits-1:0]      lk_way;

  logic                                    chk_en;
  logic [8*16-1:0]                         test_name;
  logic [num_ports-1:0]                    exp_hit;
  logic [num_ports-1:0][way_bits-1:0]      exp_way;
  logic [num_ports-1:0][ppn_bits-1:0]      exp_ppn;
  logic [num_ports-1:0][perm_bits-1:0]     exp_perm;
  int                                      pass_cnt;
  int                                      fail_cnt;
  int                                      cycles;

  row_t rows [num_rows];
  int   n_rows;

  always #10 clk = ~clk;

  dtlb_top i_dtlb_top (
    .clk      (clk),
    .rst      (rst),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .wr_op    (wr_op),
    .wr_vpn   (wr_vpn),
    .wr_asid  (wr_asid),
    .wr_ppn   (wr_ppn),
    .wr_perm  (wr_perm),
    .wr_global(wr_global),
    .lk_valid (lk_valid),
    .lk_vpn   (lk_vpn),
    .lk_asid  (lk_asid),
    .lk_hit   (lk_hit),
    .lk_ppn   (lk_ppn),
    .lk_perm  (lk_perm),
    .lk_way   (lk_way)
  );

  dtlb_checker i_checker (
    .clk      (clk),
    .rst      (rst),
    .wr_ready (wr_ready),
    .lk_hit   (lk_hit),
    .lk_ppn   (lk_ppn),
    .lk_perm  (lk_perm),
    .lk_way   (lk_way),
    .chk_en   (chk_en),
    .test_name(test_name),
    .exp_hit  (exp_hit),
    .exp_way  (exp_way),
    .exp_ppn  (exp_ppn),
    .exp_perm (exp_perm),
    .pass_cnt (pass_cnt),
    .fail_cnt (fail_cnt)
  );

  function automatic res_t hit_at(input int way, input logic [ppn_bits-1:0] ppn,
                                  input logic [perm_bits-1:0] perm);
    res_t r;
    r.hit  = 1'b1;
    r.way  = way_bits'(way);
    r.ppn  = ppn;
    r.perm = perm;
    return r;
  endfunction

  function automatic res_t miss();
    return '0;
  endfunction

  // set f is never written, so these pages always miss
  function automatic logic [vpn_bits-1:0] filler_vpn();
    return {16'($urandom), 4'hf};
  endfunction

  task automatic add_row(input logic [8*16-1:0] name, input kind_e kind,
                         input logic [vpn_bits-1:0] vpn, input logic [asid_bits-1:0] asid,
                         input logic [ppn_bits-1:0] ppn, input logic [perm_bits-1:0] perm,
                         input logic glob, input logic [vpn_bits-1:0] lk0,
                         input logic [vpn_bits-1:0] lk1, input logic [asid_bits-1:0] lka,
                         input res_t exp0, input res_t exp1);
    rows[n_rows] = {name, kind, vpn, asid, ppn, perm, glob, lk0, lk1, lka, exp0, exp1};
    n_rows++;
  endtask

  task automatic build_table();
    n_rows = 0;
    add_row("sweep_miss", k_look, 0, 0, 0, 0, 0,
            20'h00101, filler_vpn(), 8'h11, miss(), miss());
    add_row("fill_basic", k_fill, 20'h12341, 8'h11, 16'ha001, 3'd5, 1'b0,
            20'h12341, 20'h12341, 8'h11, hit_at(3, 16'ha001, 3'd5), hit_at(3, 16'ha001, 3'd5));
    add_row("unwritten_miss", k_look, 0, 0, 0, 0, 0,
            20'h55551, 20'h12341, 8'h11, miss(), hit_at(3, 16'ha001, 3'd5));
    add_row("asid_mismatch", k_look, 0, 0, 0, 0, 0,
            20'h12341, 20'h12341, 8'h22, miss(), miss());
    add_row("fill_global", k_fill, 20'h0abc2, 8'h11, 16'hb002, 3'd3, 1'b1,
            20'h0abc2, 20'h12341, 8'h22, hit_at(3, 16'hb002, 3'd3), miss());
    add_row("global_any", k_look, 0, 0, 0, 0, 0,
            20'h0abc2, 20'h0abc2, 8'h7e, hit_at(3, 16'hb002, 3'd3), hit_at(3, 16'hb002, 3'd3));
    // both pages are present, only lk_valid keeps them from hitting
    add_row("lk_valid_low", k_idle, 0, 0, 0, 0, 0,
            20'h12341, 20'h0abc2, 8'h11, miss(), miss());
    add_row("refill_same", k_fill, 20'h12341, 8'h11, 16'hc003, 3'd6, 1'b0,
            20'h12341, 20'h12341, 8'h11, hit_at(3, 16'hc003, 3'd6), hit_at(3, 16'hc003, 3'd6));
    // set 5 starts with ages 0..3, so fills walk down from way 3
    add_row("lru_fill_a", k_fill, 20'h00a05, 8'h11, 16'h0a05, 3'd1, 1'b0,
            20'h00a05, filler_vpn(), 8'h11, hit_at(3, 16'h0a05, 3'd1), miss());
    add_row("lru_fill_b", k_fill, 20'h00b05, 8'h11, 16'h0b05, 3'd2, 1'b0,
            20'h00b05, 20'h00a05, 8'h11, hit_at(2, 16'h0b05, 3'd2), hit_at(3, 16'h0a05, 3'd1));
    add_row("lru_fill_c", k_fill, 20'h00c05, 8'h11, 16'h0c05, 3'd3, 1'b0,
            20'h00c05, 20'h00b05, 8'h11, hit_at(1, 16'h0c05, 3'd3), hit_at(2, 16'h0b05, 3'd2));
    add_row("lru_fill_d", k_fill, 20'h00d05, 8'h11, 16'h0d05, 3'd4, 1'b0,
            20'h00d05, 20'h00c05, 8'h11, hit_at(0, 16'h0d05, 3'd4), hit_at(1, 16'h0c05, 3'd3));
    add_row("lru_fill_e", k_fill, 20'h00e05, 8'h11, 16'h0e05, 3'd7, 1'b0,
            20'h00e05, 20'h00a05, 8'h11, hit_at(3, 16'h0e05, 3'd7), miss());
    // way 2 is oldest here, a port 0 hit leaves way 1 as victim
    add_row("lru_touch", k_look, 0, 0, 0, 0, 0,
            20'h00b05, 20'h00c05, 8'h11, hit_at(2, 16'h0b05, 3'd2), hit_at(1, 16'h0c05, 3'd3));
    add_row("lru_after_touch", k_fill, 20'h00f05, 8'h11, 16'h0f05, 3'd0, 1'b0,
            20'h00f05, 20'h00b05, 8'h11, hit_at(1, 16'h0f05, 3'd0), hit_at(2, 16'h0b05, 3'd2));
    add_row("inval_hit", k_inval, 20'h00d05, 8'h11, 0, 0, 0,
            20'h00d05, 20'h00e05, 8'h11, miss(), hit_at(3, 16'h0e05, 3'd7));
    add_row("inval_others", k_look, 0, 0, 0, 0, 0,
            20'h00b05, 20'h00f05, 8'h11, hit_at(2, 16'h0b05, 3'd2), hit_at(1, 16'h0f05, 3'd0));
    add_row("inval_absent", k_inval, 20'h77775, 8'h11, 0, 0, 0,
            20'h00e05, 20'h00b05, 8'h11, hit_at(3, 16'h0e05, 3'd7), hit_at(2, 16'h0b05, 3'd2));
    add_row("inval_asid", k_inval, 20'h12341, 8'h22, 0, 0, 0,
            20'h12341, filler_vpn(), 8'h11, hit_at(3, 16'hc003, 3'd6), miss());
  endtask

  task automatic apply_row(input row_t r);
    wr_valid  <= (r.kind == k_fill) || (r.kind == k_inval);
    wr_op     <= (r.kind == k_inval) ? op_inval : op_fill;
    wr_vpn    <= r.vpn;
    wr_asid   <= r.asid;
    wr_ppn    <= r.ppn;
    wr_perm   <= r.perm;
    wr_global <= r.glob;
    lk_valid  <= {num_ports{r.kind != k_idle}};
    lk_vpn[0] <= r.lk0;
    lk_vpn[1] <= r.lk1;
    lk_asid   <= r.lk_asid;
    chk_en    <= 1'b0;
  endtask

  task automatic arm_check(input row_t r);
    chk_en    <= 1'b1;
    test_name <= r.name;
    exp_hit   <= {r.exp1.hit, r.exp0.hit};
    exp_way   <= {r.exp1.way, r.exp0.way};
    exp_ppn   <= {r.exp1.ppn, r.exp0.ppn};
    exp_perm  <= {r.exp1.perm, r.exp0.perm};
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h60e6_a2a8));
    rst       = 1'b1;
    wr_valid  = 1'b0;
    wr_op     = op_fill;
    wr_vpn    = '0;
    wr_asid   = '0;
    wr_ppn    = '0;
    wr_perm   = '0;
    wr_global = 1'b0;
    lk_valid  = '1;
    lk_vpn[0] = filler_vpn();
    lk_vpn[1] = filler_vpn();
    lk_asid   = '0;
    chk_en    = 1'b0;
    test_name = '0;
    exp_hit   = '0;
    exp_way   = '0;
    exp_ppn   = '0;
    exp_perm  = '0;
    build_table();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    while (!wr_ready) @(posedge clk);
    for (int i = 0; i < n_rows; i++) begin
      apply_row(rows[i]);
      @(posedge clk);
      while (wr_valid && !wr_ready) @(posedge clk);
      wr_valid <= 1'b0;
      arm_check(rows[i]);
      @(posedge clk);
    end
    chk_en <= 1'b0;
    repeat (2) @(posedge clk);
    $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == num_rows + 1) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- dtlb.f
hw/tlb_geom_pkg.sv
hw/tlb_ctrl_pkg.sv
hw/tlb_way.sv
hw/tlb_lru.sv
hw/tlb_fill_ctrl.sv
hw/dtlb_top.sv
bench/dtlb_checker.sv
bench/tb_dtlb.sv

//--- hw/dtlb_top.sv
/*
  dtlb_top
  Four-way, sixteen-set data TLB with two combinational lookup ports and
  one write port for fills and invalidates. Merges the per-way hits of
  each port into a hit flag, the way number and its ppn and perm.
*/
`timescale 1ns/1ps

module dtlb_top (
  input  logic                                                             clk,
  input  logic                                                             rst,
  input  logic                                                             wr_valid,
  output logic                                                             wr_ready,
  input  tlb_ctrl_pkg::tlb_op_e                                            wr_op,
  input  logic [tlb_geom_pkg::vpn_bits-1:0]                                wr_vpn,
  input  logic [tlb_geom_pkg::asid_bits-1:0]                               wr_asid,
  input  logic [tlb_geom_pkg::ppn_bits-1:0]                                wr_ppn,
  input  logic [tlb_geom_pkg::perm_bits-1:0]                               wr_perm,
  input  logic                                                             wr_global,
  input  logic [tlb_geom_pkg::num_ports-1:0]                               lk_valid,
  input  logic [tlb_geom_pkg::num_ports-1:0][tlb_geom_pkg::vpn_bits-1:0]  lk_vpn,
  input  logic [tlb_geom_pkg::asid_bits-1:0]                               lk_asid,
  output logic [tlb_geom_pkg::num_ports-1:0]                               lk_hit,
  output logic [tlb_geom_pkg::num_ports-1:0][tlb_geom_pkg::ppn_bits-1:0]  lk_ppn,
  output logic [tlb_geom_pkg::num_ports-1:0][tlb_geom_pkg::perm_bits-1:0] lk_perm,
  output logic [tlb_geom_pkg::num_ports-1:0][tlb_geom_pkg::way_bits-1:0]  lk_way
);
  import tlb_geom_pkg::*;

  logic [num_ways-1:0][num_ports-1:0]                way_hit;
  logic [num_ways-1:0][num_ports-1:0][ppn_bits-1:0]  way_ppn;
  logic [num_ways-1:0][num_ports-1:0][perm_bits-1:0] way_perm;
  logic [num_ways-1:0]                               probe_hit;
  logic [num_ways-1:0]                               way_wen;
  logic [num_ports-1:0]                              raw_hit;
  logic [set_bits-1:0]                               widx;
  logic                                              clear;
  logic                                              sweeping;
  logic                                              fill_touch;
  logic [way_bits-1:0]                               fill_way;
  logic [way_bits-1:0]                               victim_way;

  for (genvar w = 0; w < num_ways; w++) begin : g_way
    tlb_way i_tlb_way (
      .clk       (clk),
      .rst       (rst),
      .lk_vpn    (lk_vpn),
      .lk_asid   (lk_asid),
      .lk_hit    (way_hit[w]),
      .lk_ppn    (way_ppn[w]),
      .lk_perm   (way_perm[w]),
      .probe_vpn (wr_vpn),
      .probe_asid(wr_asid),
      .probe_hit (probe_hit[w]),
      .wen       (way_wen[w]),
      .clear     (clear),
      .widx      (widx),
      .wvpn      (wr_vpn),
      .wasid     (wr_asid),
      .wppn      (wr_ppn),
      .wperm     (wr_perm),
      .wglobal   (wr_global)
    );
  end

  // widx carries the sweep set while sweeping and the fill set after
  tlb_lru i_tlb_lru (
    .clk       (clk),
    .rst       (rst),
    .sweeping  (sweeping),
    .sweep_idx (widx),
    .lk_touch  (lk_hit[0]),
    .lk_set    (lk_vpn[0][set_bits-1:0]),
    .lk_way    (lk_way[0]),
    .fill_touch(fill_touch),
    .fill_set  (widx),
    .fill_way  (fill_way),
    .victim_set(wr_vpn[set_bits-1:0]),
    .victim_way(victim_way)
  );

  tlb_fill_ctrl i_tlb_fill_ctrl (
    .clk       (clk),
    .rst       (rst),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready),
    .wr_op     (wr_op),
    .wr_vpn    (wr_vpn),
    .probe_hit (probe_hit),
    .victim_way(victim_way),
    .way_wen   (way_wen),
    .widx      (widx),
    .clear     (clear),
    .sweeping  (sweeping),
    .fill_touch(fill_touch),
    .fill_way  (fill_way)
  );

  // hit merge per port
  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      raw_hit[p] = 1'b0;
      lk_ppn[p]  = '0;
      lk_perm[p] = '0;
      lk_way[p]  = '0;
      for (int w = 0; w < num_ways; w++) begin
        if (way_hit[w][p]) begin
          raw_hit[p] = 1'b1;
          lk_ppn[p]  = way_ppn[w][p];
          lk_perm[p] = way_perm[w][p];
          lk_way[p]  = way_bits'(w);
        end
      end
      lk_hit[p] = raw_hit[p] && lk_valid[p] && !sweeping;
    end
  end

endmodule

//--- hw/tlb_ctrl_pkg.sv
/*
  dtlb control encodings
  Write port opcodes and the states of the reset sweep machine.
*/
package tlb_ctrl_pkg;

  // write port request kind
  typedef enum logic {
    op_fill,
    op_inval
  } tlb_op_e;

  // clearing all sets, then normal operation
  typedef enum logic {
    st_sweep,
    st_run
  } sweep_state_e;

endpackage

//--- hw/tlb_fill_ctrl.sv
/*
  tlb_fill_ctrl
  Runs the reset sweep over all sets, then serves the write port. A fill
  rewrites the way that already holds the page, or else the LRU victim.
  An invalidate clears only the way that holds the page.
*/
`timescale 1ns/1ps

module tlb_fill_ctrl (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              wr_valid,
  output logic                              wr_ready,
  input  tlb_ctrl_pkg::tlb_op_e             wr_op,
  input  logic [tlb_geom_pkg::vpn_bits-1:0] wr_vpn,
  input  logic [tlb_geom_pkg::num_ways-1:0] probe_hit,
  input  logic [tlb_geom_pkg::way_bits-1:0] victim_way,
  output logic [tlb_geom_pkg::num_ways-1:0] way_wen,
  output logic [tlb_geom_pkg::set_bits-1:0] widx,
  output logic                              clear,
  output logic                              sweeping,
  output logic                              fill_touch,
  output logic [tlb_geom_pkg::way_bits-1:0] fill_way
);
  import tlb_geom_pkg::*;
  import tlb_ctrl_pkg::*;

  sweep_state_e        state;
  logic [set_bits-1:0] sweep_cnt;
  logic                accept;
  logic                probe_any;
  logic [way_bits-1:0] probe_way;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_sweep;
      sweep_cnt <= '0;
    end else if (state == st_sweep) begin
      sweep_cnt <= sweep_cnt + 1'b1;
      if (sweep_cnt == set_bits'(sweep_len - 1)) begin
        state <= st_run;
      end
    end
  end

  assign sweeping = (state == st_sweep);
  assign wr_ready = (state == st_run);
  assign accept   = wr_valid && wr_ready;

  // at most one way holds a given page
  always_comb begin
    probe_any = |probe_hit;
    probe_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (probe_hit[w]) begin
        probe_way = way_bits'(w);
      end
    end
  end

  always_comb begin
    way_wen    = '0;
    widx       = wr_vpn[set_bits-1:0];
    clear      = 1'b0;
    fill_touch = 1'b0;
    fill_way   = probe_any ? probe_way : victim_way;
    if (sweeping) begin
      way_wen = '1;
      widx    = sweep_cnt;
      clear   = 1'b1;
    end else if (accept && wr_op == op_fill) begin
      fill_touch = 1'b1;
      if (probe_any) begin
        way_wen = probe_hit;
      end else begin
        way_wen[victim_way] = 1'b1;
      end
    end else if (accept) begin
      // invalidate miss leaves way_wen at zero
      way_wen = probe_hit;
      clear   = 1'b1;
    end
  end

endmodule

//--- hw/tlb_geom_pkg.sv
/*
  dtlb geometry
  Sizes of the data TLB and the widths of the fields held in each entry.
  The set index is the low set_bits of the virtual page number, and the
  stored tag is the full page number.
*/
package tlb_geom_pkg;

  // organisation
  localparam int num_ways  = 4;
  localparam int num_sets  = 16;
  localparam int set_bits  = 4;
  localparam int way_bits  = 2;
  localparam int num_ports = 2;

  // entry fields
  localparam int vpn_bits  = 20;
  localparam int ppn_bits  = 16;
  localparam int asid_bits = 8;
  localparam int perm_bits = 3;

  // one age per way, 0 is most recently used
  localparam int age_bits  = 2;

  // cycles spent clearing sets after reset
  localparam int sweep_len = 16;

endpackage

//--- hw/tlb_lru.sv
/*
  tlb_lru
  Per-set ages for the four ways. A touched way goes to age 0 and every
  way younger than it ages by one. The way at the oldest age is the
  victim for the next fill of that set.
*/
`timescale 1ns/1ps

module tlb_lru (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              sweeping,
  input  logic [tlb_geom_pkg::set_bits-1:0] sweep_idx,
  input  logic                              lk_touch,
  input  logic [tlb_geom_pkg::set_bits-1:0] lk_set,
  input  logic [tlb_geom_pkg::way_bits-1:0] lk_way,
  input  logic                              fill_touch,
  input  logic [tlb_geom_pkg::set_bits-1:0] fill_set,
  input  logic [tlb_geom_pkg::way_bits-1:0] fill_way,
  input  logic [tlb_geom_pkg::set_bits-1:0] victim_set,
  output logic [tlb_geom_pkg::way_bits-1:0] victim_way
);
  import tlb_geom_pkg::*;

  logic [age_bits-1:0] age [num_sets][num_ways];
  logic                touch;
  logic [set_bits-1:0] t_set;
  logic [way_bits-1:0] t_way;
  logic [age_bits-1:0] t_age;

  // fill wins, a same-cycle port 0 hit is dropped
  assign touch = !rst && (fill_touch || lk_touch);
  assign t_set = fill_touch ? fill_set : lk_set;
  assign t_way = fill_touch ? fill_way : lk_way;
  assign t_age = age[t_set][t_way];

  always_ff @(posedge clk) begin
    if (sweeping) begin
      // seed way k with age k
      for (int k = 0; k < num_ways; k++) begin
        age[sweep_idx][k] <= age_bits'(k);
      end
    end else if (touch) begin
      for (int k = 0; k < num_ways; k++) begin
        if (way_bits'(k) == t_way) begin
          age[t_set][k] <= '0;
        end else if (age[t_set][k] < t_age) begin
          age[t_set][k] <= age[t_set][k] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    victim_way = '0;
    for (int k = 0; k < num_ways; k++) begin
      if (age[victim_set][k] == age_bits'(num_ways - 1)) begin
        victim_way = way_bits'(k);
      end
    end
  end

endmodule

//--- hw/tlb_way.sv
/*
  tlb_way
  One way of the data TLB. Holds an entry per set and runs the hit rule
  for every lookup port and for the write probe: valid entry, equal page
  number, and equal asid unless the entry is global.
*/
`timescale 1ns/1ps

module tlb_way (
  input  logic clk,
  input  logic rst,
  input  logic [tlb_geom_pkg::num_ports-1:0][tlb_geom_pkg::vpn_bits-1:0]  lk_vpn,
  input  logic [tlb_geom_pkg::asid_bits-1:0]                               lk_asid,
  output logic [tlb_geom_pkg::num_ports-1:0]                               lk_hit,
  output logic [tlb_geom_pkg::num_ports-1:0][tlb_geom_pkg::ppn_bits-1:0]  lk_ppn,
  output logic [tlb_geom_pkg::num_ports-1:0][tlb_geom_pkg::perm_bits-1:0] lk_perm,
  input  logic [tlb_geom_pkg::vpn_bits-1:0]                                probe_vpn,
  input  logic [tlb_geom_pkg::asid_bits-1:0]                               probe_asid,
  output logic                                                             probe_hit,
  input  logic                                                             wen,
  input  logic                                                             clear,
  input  logic [tlb_geom_pkg::set_bits-1:0]                                widx,
  input  logic [tlb_geom_pkg::vpn_bits-1:0]                                wvpn,
  input  logic [tlb_geom_pkg::asid_bits-1:0]                               wasid,
  input  logic [tlb_geom_pkg::ppn_bits-1:0]                                wppn,
  input  logic [tlb_geom_pkg::perm_bits-1:0]                               wperm,
  input  logic                                                             wglobal
);
  import tlb_geom_pkg::*;

  logic [num_sets-1:0]  vld;
  logic [num_sets-1:0]  glob;
  logic [vpn_bits-1:0]  tag  [num_sets];
  logic [asid_bits-1:0] asid [num_sets];
  logic [ppn_bits-1:0]  ppn  [num_sets];
  logic [perm_bits-1:0] perm [num_sets];

  function automatic logic match(input logic [vpn_bits-1:0]  vpn,
                                 input logic [asid_bits-1:0] id);
    logic [set_bits-1:0] idx;
    idx = vpn[set_bits-1:0];
    return vld[idx] && (tag[idx] == vpn) && ((asid[idx] == id) || glob[idx]);
  endfunction

  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      lk_hit[p]  = match(lk_vpn[p], lk_asid);
      lk_ppn[p]  = ppn[lk_vpn[p][set_bits-1:0]];
      lk_perm[p] = perm[lk_vpn[p][set_bits-1:0]];
    end
    probe_hit = match(probe_vpn, probe_asid);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld <= '0;
    end else if (wen) begin
      vld[widx] <= !clear;
    end
  end

  // a clear only drops valid, the fields stay as they were
  always_ff @(posedge clk) begin
    if (wen && !clear) begin
      tag[widx]  <= wvpn;
      asid[widx] <= wasid;
      glob[widx] <= wglobal;
      ppn[widx]  <= wppn;
      perm[widx] <= wperm;
    end
  end

endmodule
